//--- rtl/isaPkg.sv
/*
  Instruction-set encodings for the supported MIPS subset.
  Holds the opcode and function-code values and the instruction word
  union that gives the R, I and J views of one 32-bit word.
*/
`default_nettype none

package isaPkg;

  // ========================================================================
  // primary opcodes, instr[31:26]
  // ========================================================================
  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_SW    = 6'b101011;
  localparam logic [5:0] OP_BEQ   = 6'b000100;
  localparam logic [5:0] OP_J     = 6'b000010;
  localparam logic [5:0] OP_JAL   = 6'b000011;

  // function codes, only meaningful with OP_RTYPE
  localparam logic [5:0] FN_ADD = 6'b100000;
  localparam logic [5:0] FN_SUB = 6'b100010;
  localparam logic [5:0] FN_AND = 6'b100100;
  localparam logic [5:0] FN_OR  = 6'b100101;
  localparam logic [5:0] FN_SLT = 6'b101010;
  localparam logic [5:0] FN_JR  = 6'b001000;

  // ========================================================================
  // instruction formats
  // ========================================================================
  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rTypeT;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeT;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } jTypeT;

  // one fetched word, read through whichever format the opcode selects
  typedef union packed {
    rTypeT rType;
    iTypeT iType;
    jTypeT jType;
  } instrWordT;

endpackage

`default_nettype wire

//--- rtl/corePkg.sv
/*
  Datapath types shared by the core, the data memory and the top level.
  Control word, ALU operation, data memory request and write-back trace.
*/
`default_nettype none

package corePkg;

  // data memory geometry, word addressed
  localparam int DMEM_AW    = 7;
  localparam int DMEM_WORDS = 128;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_SLT  = 3'd4,
    ALU_NONE = 3'd5
  } aluOpT;

  // decoded control, one per instruction
  typedef struct packed {
    logic  regDst;
    logic  aluSrc;
    logic  memToReg;
    logic  regWrite;
    logic  memWrite;
    logic  jump;
    logic  branch;
    logic  link;
    logic  jumpReg;
    aluOpT aluOp;
  } ctrlT;

  // strobes are active high
  typedef struct packed {
    logic               chipEn;
    logic               writeEn;
    logic [DMEM_AW-1:0] addr;
    logic [31:0]        writeData;
  } memReqT;

  // register write-back, committed at the next rising edge
  typedef struct packed {
    logic        valid;
    logic [4:0]  addr;
    logic [31:0] data;
  } wbInfoT;

endpackage

`default_nettype wire

//--- rtl/controlUnit.sv
/*
  Instruction decoder. Turns opcode and function code into the control
  word, ALU operation included, in a single combinational step.
  Unknown opcodes decode to a no-op; unknown R-type functions give ALU_NONE.
*/
`default_nettype none
`timescale 1ns/100ps

module controlUnit (
  input  isaPkg::instrWordT instr,
  output corePkg::ctrlT     ctrl
);

  import isaPkg::*;
  import corePkg::*;

  always_comb begin
    // start from a no-op, nothing written
    ctrl       = '0;
    ctrl.aluOp = ALU_NONE;

    case (instr.rType.op)
      OP_RTYPE: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (instr.rType.funct)
          FN_ADD: ctrl.aluOp = ALU_ADD;
          FN_SUB: ctrl.aluOp = ALU_SUB;
          FN_AND: ctrl.aluOp = ALU_AND;
          FN_OR:  ctrl.aluOp = ALU_OR;
          FN_SLT: ctrl.aluOp = ALU_SLT;
          FN_JR: begin
            // jr only redirects the PC
            ctrl.jumpReg  = 1'b1;
            ctrl.regWrite = 1'b0;
          end
          // undefined function, result 0 still written to rd
          default: ctrl.aluOp = ALU_NONE;
        endcase
      end
      OP_LW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = ALU_ADD;
      end
      OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = ALU_ADD;
      end
      OP_BEQ: begin
        // equality from the zero flag of rs - rt
        ctrl.branch = 1'b1;
        ctrl.aluOp  = ALU_SUB;
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl.aluOp = ALU_NONE;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
/*
  General purpose register file, 32 x 32 bits.
  Two combinational read ports, one write port at the rising edge.
  Register 0 reads as zero and ignores writes.
*/
`default_nettype none
`timescale 1ns/100ps

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  rAddr1,
  input  logic [4:0]  rAddr2,
  input  logic [4:0]  wAddr,
  input  logic [31:0] wData,
  output logic [31:0] rData1,
  output logic [31:0] rData2
);

  logic [31:0] regs [32];

  // whole array cleared while rst is low
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != 5'd0)) begin
      regs[wAddr] <= wData;
    end
  end

  // r0 hardwired to zero
  assign rData1 = (rAddr1 == 5'd0) ? 32'd0 : regs[rAddr1];
  assign rData2 = (rAddr2 == 5'd0) ? 32'd0 : regs[rAddr2];

endmodule

`default_nettype wire

//--- rtl/alu.sv
/*
  Combinational ALU for add, sub, and, or and signed slt.
  ALU_NONE and any other code give a zero result.
*/
`default_nettype none
`timescale 1ns/100ps

module alu (
  input  logic [31:0]   a,
  input  logic [31:0]   b,
  input  corePkg::aluOpT op,
  output logic [31:0]   result,
  output logic          zero
);

  import corePkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // two's complement compare
      ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: result = 32'd0;
    endcase
  end

  // used by beq with ALU_SUB
  assign zero = (result == 32'd0);

endmodule

`default_nettype wire

//--- rtl/pcUnit.sv
/*
  Program counter and next-address selection.
  Priority is jump, then taken beq, then jr, then sequential PC+4.
  The PC is held at 0 while rst is low.
*/
`default_nettype none
`timescale 1ns/100ps

module pcUnit (
  input  logic          clk,
  input  logic          rst,
  input  corePkg::ctrlT ctrl,
  input  logic          zero,
  input  logic [25:0]   target,
  input  logic [31:0]   offset,
  input  logic [31:0]   jrAddr,
  output logic [31:0]   pc,
  output logic [31:0]   pcPlus4
);

  logic [31:0] jumpAddr;
  logic [31:0] branchAddr;
  logic [31:0] nextPc;
  logic        branchTaken;

  assign pcPlus4 = pc + 32'd4;

  // region of pc+4, word target
  assign jumpAddr = {pcPlus4[31:28], target, 2'b00};

  // word offset relative to the delay-free next PC
  assign branchAddr  = pcPlus4 + {offset[29:0], 2'b00};
  assign branchTaken = ctrl.branch & zero;

  // ==========================================================================
  // next address
  // ==========================================================================
  always_comb begin
    if (ctrl.jump) begin
      nextPc = jumpAddr;
    end else if (branchTaken) begin
      nextPc = branchAddr;
    end else if (ctrl.jumpReg) begin
      nextPc = jrAddr;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= 32'd0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dataSram.sv
/*
  Data memory, 128 words of 32 bits.
  Write at the rising edge when chipEn and writeEn are both high,
  read combinationally at the request address. Cleared on reset.
*/
`default_nettype none
`timescale 1ns/100ps

module dataSram (
  input  logic            clk,
  input  logic            rst,
  input  corePkg::memReqT req,
  output logic [31:0]     readData
);

  import corePkg::*;

  logic [31:0] mem [DMEM_WORDS];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (req.chipEn && req.writeEn) begin
      mem[req.addr] <= req.writeData;
    end
  end

  // same-cycle read for lw
  assign readData = mem[req.addr];

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
/*
  Single-cycle core datapath. Connects decoder, register file, ALU and
  PC unit, selects write destination and write-back data, and drives the
  data memory request and the write-back trace. One instruction per clock.
*/
`default_nettype none
`timescale 1ns/100ps

module mipsCore (
  input  logic              clk,
  input  logic              rst,
  input  isaPkg::instrWordT instr,
  output logic [31:0]       instrAddr,
  output corePkg::memReqT   memReq,
  input  logic [31:0]       readData,
  output corePkg::wbInfoT   wb
);

  import corePkg::*;

  ctrlT        ctrl;
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [31:0] signImm;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [4:0]  wAddr;
  logic [31:0] wData;

  // ==========================================================================
  // decode, operands, execute
  // ==========================================================================
  controlUnit u_ctrl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  regFile u_regs (
    .clk    (clk),
    .rst    (rst),
    .we     (ctrl.regWrite),
    .rAddr1 (instr.rType.rs),
    .rAddr2 (instr.rType.rt),
    .wAddr  (wAddr),
    .wData  (wData),
    .rData1 (rsData),
    .rData2 (rtData)
  );

  // offset for lw, sw and beq
  assign signImm = {{16{instr.iType.imm[15]}}, instr.iType.imm};
  assign aluB    = ctrl.aluSrc ? signImm : rtData;

  alu u_alu (
    .a      (rsData),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  pcUnit u_pc (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .zero    (aluZero),
    .target  (instr.jType.target),
    .offset  (signImm),
    .jrAddr  (rsData),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  assign instrAddr = pc;

  // ==========================================================================
  // write-back selection
  // ==========================================================================
  always_comb begin
    // jal links to r31
    if (ctrl.link) begin
      wAddr = 5'd31;
    end else if (ctrl.regDst) begin
      wAddr = instr.rType.rd;
    end else begin
      wAddr = instr.rType.rt;
    end

    if (ctrl.link) begin
      wData = pcPlus4;
    end else if (ctrl.memToReg) begin
      wData = readData;
    end else begin
      wData = aluResult;
    end
  end

  // memory request, byte address bits 8:2 select the word
  assign memReq.chipEn    = rst & (ctrl.memToReg | ctrl.memWrite);
  assign memReq.writeEn   = rst & ctrl.memWrite;
  assign memReq.addr      = aluResult[DMEM_AW+1:2];
  assign memReq.writeData = rtData;

  // trace only the writes that actually land, never r0
  assign wb.valid = rst & ctrl.regWrite & (wAddr != 5'd0);
  assign wb.addr  = wAddr;
  assign wb.data  = wData;

endmodule

`default_nettype wire

//--- rtl/mipsSystem.sv
/*
  Top level of the subsystem. The core plus its internal data memory.
  Instruction memory sits outside and answers instrAddr on instr.
*/
`default_nettype none
`timescale 1ns/100ps

module mipsSystem (
  input  logic              clk,
  input  logic              rst,
  input  isaPkg::instrWordT instr,
  output logic [31:0]       instrAddr,
  output corePkg::wbInfoT   wb
);

  import corePkg::*;

  memReqT      memReq;
  logic [31:0] readData;

  mipsCore u_core (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .instrAddr (instrAddr),
    .memReq    (memReq),
    .readData  (readData),
    .wb        (wb)
  );

  dataSram u_dmem (
    .clk      (clk),
    .rst      (rst),
    .req      (memReq),
    .readData (readData)
  );

endmodule

`default_nettype wire

//--- bench/mipsCore_properties.sv
/*
  Concurrent checks on the core, attached to every mipsCore by bind.
  Strobe consistency, word-aligned fetch and quiet outputs in reset.
*/
`default_nettype none
`timescale 1ns/100ps

module mipsCore_properties (
  input logic            clk,
  input logic            rst,
  input logic [31:0]     instrAddr,
  input corePkg::memReqT memReq,
  input corePkg::wbInfoT wb
);

  // a store always selects the memory
  writeNeedsChip: assert property (@(posedge clk) memReq.writeEn |-> memReq.chipEn)
    else $error("data memory write strobe without chip enable");

  // fetch is by whole words
  pcAligned: assert property (@(posedge clk) instrAddr[1:0] == 2'b00)
    else $error("instruction address not word aligned");

  quietInReset: assert property (@(posedge clk)
    !rst |-> !(wb.valid || memReq.chipEn || memReq.writeEn))
    else $error("write-back or memory strobe active during reset");

endmodule

bind mipsCore mipsCore_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .memReq    (memReq),
  .wb        (wb)
);

`default_nettype wire

//--- bench/tbMipsSystem.sv
/*
  Testbench for the MIPS subsystem. Builds a forward-only random program,
  serves it as instruction memory, and runs a behavioral ISA model in step
  with the DUT. PC and write-back trace are compared on every falling edge.
*/
`default_nettype none
`timescale 1ns/100ps

module tbMipsSystem;

  import isaPkg::*;
  import corePkg::*;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 8;
  localparam int          PROG_LEN     = 200;
  localparam int          IMEM_WORDS   = 256;
  localparam int          SEED_PAIRS   = 10;
  localparam logic [31:0] SEED         = 32'd55090;
  localparam logic [31:0] END_ADDR     = 32'((PROG_LEN - 1) * 4);

  logic        clk;
  logic        rst;
  instrWordT   instr;
  logic [31:0] instrAddr;
  wbInfoT      wb;

  // program image
  instrWordT   imem [IMEM_WORDS];
  // slotKind 0 marks a free slot, 1 a taken one and 2 one inside a jal/jr block
  logic [1:0]  slotKind [IMEM_WORDS];
  logic [31:0] rngState;

  // reference ISA state
  logic [31:0] refRegs [32];
  logic [31:0] refMem [DMEM_WORDS];
  logic [31:0] refPc;
  int          cycles;
  int          tailCycles;

  mipsSystem u_mipsSystem (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .instrAddr (instrAddr),
    .wb        (wb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // covers reset and the whole program with a few cycles of margin
  initial begin
    #((RESET_CYCLES + PROG_LEN + 50) * CLK_PERIOD);
    $display("watchdog expired before the program reached its final self-jump");
    $display("Regression failed");
    $fatal(1, "timeout");
  end

  // ==========================================================================
  // random numbers and instruction encoding
  // ==========================================================================
  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1103515245 + 32'd12345;
    return rngState >> 8;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return nextRand() % n;
  endfunction

  function automatic instrWordT encR(input int rs, input int rt, input int rd,
                                     input logic [5:0] fn);
    instrWordT w;
    w.rType = '{OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    return w;
  endfunction

  function automatic instrWordT encI(input logic [5:0] op, input int rs, input int rt,
                                     input int imm);
    instrWordT w;
    w.iType = '{op, 5'(rs), 5'(rt), 16'(imm)};
    return w;
  endfunction

  function automatic instrWordT encJ(input logic [5:0] op, input int t);
    instrWordT w;
    w.jType = '{op, 26'(t)};
    return w;
  endfunction

  function automatic logic [5:0] randFunct();
    case (pick(6))
      0: return FN_ADD;
      1: return FN_SUB;
      2: return FN_AND;
      3: return FN_OR;
      4: return FN_SLT;
      // nor is not implemented and gives 0
      default: return 6'b100111;
    endcase
  endfunction

  task automatic buildProgram();
    int i;
    int t;
    int rs;
    int word;
    int unsigned kind;
    for (i = 0; i < IMEM_WORDS; i++) begin
      // every unused slot jumps to itself
      imem[i]     = encJ(OP_J, i);
      slotKind[i] = 2'd0;
    end
    // link values mixed into r1..r10 give nonzero operands
    for (i = 0; i < SEED_PAIRS; i++) begin
      imem[2 * i]     = encJ(OP_JAL, 2 * i + 1);
      imem[2 * i + 1] = encR(i, 31, i + 1, (i % 2 == 0) ? FN_SUB : FN_ADD);
    end
    // jal to a body and jr back to a j that skips it
    i = 2 * SEED_PAIRS;
    while (i < PROG_LEN - 5) begin
      if (pick(12) == 0) begin
        imem[i]     = encJ(OP_JAL, i + 2);
        imem[i + 1] = encJ(OP_J, i + 4);
        imem[i + 2] = encR(pick(32), pick(32), 1 + pick(30), randFunct());
        imem[i + 3] = encR(31, 0, 0, FN_JR);
        slotKind[i]     = 2'd1;
        slotKind[i + 1] = 2'd2;
        slotKind[i + 2] = 2'd2;
        slotKind[i + 3] = 2'd2;
        i += 4;
      end else begin
        i++;
      end
    end
    for (i = 2 * SEED_PAIRS; i < PROG_LEN - 1; i++) begin
      if (slotKind[i] == 2'd0) begin
        kind = pick(10);
        // forward target that never lands inside a block
        t = i + 2 + pick(4);
        while (t < PROG_LEN - 1 && slotKind[t] == 2'd2) t++;
        if (t > PROG_LEN - 1) t = PROG_LEN - 1;
        word = (pick(2) == 0) ? pick(16) : pick(DMEM_WORDS);
        if (kind < 5) begin
          imem[i] = encR(pick(32), pick(32), pick(32), randFunct());
        end else if (kind == 5) begin
          imem[i] = encI(OP_LW, 0, pick(32), 4 * word);
        end else if (kind == 6) begin
          imem[i] = encI(OP_SW, 0, pick(32), 4 * word);
          // read the same word back at once
          if (i + 1 < PROG_LEN - 1 && slotKind[i + 1] == 2'd0) begin
            imem[i + 1]     = encI(OP_LW, 0, 1 + pick(31), 4 * word);
            slotKind[i + 1] = 2'd1;
          end
        end else if (kind < 9) begin
          rs      = pick(32);
          imem[i] = encI(OP_BEQ, rs, (pick(2) == 0) ? rs : pick(32), t - i - 1);
        end else begin
          imem[i] = encJ(OP_J, t);
        end
      end
    end
  endtask

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic failRun();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkPc(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: pc expected 0x%08h actual 0x%08h", name, exp, act);
      failRun();
    end
  endtask

  task automatic checkTrace(input string name, input wbInfoT exp, input wbInfoT act);
    if (act.valid !== exp.valid ||
        (exp.valid && (act.addr !== exp.addr || act.data !== exp.data))) begin
      $display("[ERROR] %s: trace expected v%0b r%0d 0x%08h actual v%0b r%0d 0x%08h",
               name, exp.valid, exp.addr, exp.data, act.valid, act.addr, act.data);
      failRun();
    end
  endtask

  // ==========================================================================
  // reference model stepping one instruction per call
  // ==========================================================================
  task automatic checkAndAdvance();
    instrWordT   w;
    wbInfoT      expWb;
    logic [31:0] pc4;
    logic [31:0] sext;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] ea;
    logic [31:0] nextPc;
    w      = imem[refPc[9:2]];
    pc4    = refPc + 32'd4;
    sext   = {{16{w.iType.imm[15]}}, w.iType.imm};
    rsVal  = refRegs[w.rType.rs];
    rtVal  = refRegs[w.rType.rt];
    ea     = rsVal + sext;
    nextPc = pc4;
    expWb  = '0;
    case (w.rType.op)
      OP_RTYPE: begin
        expWb.valid = 1'b1;
        expWb.addr  = w.rType.rd;
        case (w.rType.funct)
          FN_ADD: expWb.data = rsVal + rtVal;
          FN_SUB: expWb.data = rsVal - rtVal;
          FN_AND: expWb.data = rsVal & rtVal;
          FN_OR:  expWb.data = rsVal | rtVal;
          FN_SLT: expWb.data = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
          FN_JR: begin
            expWb.valid = 1'b0;
            nextPc      = rsVal;
          end
          default: expWb.data = 32'd0;
        endcase
      end
      OP_LW: begin
        expWb = '{1'b1, w.iType.rt, refMem[ea[8:2]]};
      end
      OP_SW: refMem[ea[8:2]] = rtVal;
      OP_BEQ: begin
        if (rsVal == rtVal) nextPc = pc4 + {sext[29:0], 2'b00};
      end
      OP_J: nextPc = {pc4[31:28], w.jType.target, 2'b00};
      OP_JAL: begin
        nextPc = {pc4[31:28], w.jType.target, 2'b00};
        expWb  = '{1'b1, 5'd31, pc4};
      end
      default: ;
    endcase
    // writes to r0 are dropped
    if (expWb.addr == 5'd0) expWb.valid = 1'b0;
    checkPc($sformatf("instr at 0x%08h", refPc), refPc, instrAddr);
    checkTrace($sformatf("instr at 0x%08h", refPc), expWb, wb);
    if (expWb.valid) refRegs[expWb.addr] = expWb.data;
    refPc = nextPc;
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    rst        = 1'b0;
    instr      = '0;
    cycles     = 0;
    tailCycles = 0;
    rngState   = SEED;
    refPc      = 32'd0;
    for (int i = 0; i < 32; i++) refRegs[i] = 32'd0;
    for (int i = 0; i < DMEM_WORDS; i++) refMem[i] = 32'd0;
    buildProgram();

    // PC parked at 0 and no write-back while in reset
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      instr = imem[instrAddr[9:2]];
      #1;
      checkPc("reset", 32'd0, instrAddr);
      checkTrace("reset", '0, wb);
    end
    @(negedge clk);
    rst = 1'b1;

    // run until a few cycles spent on the final self-jump
    while (tailCycles < 4) begin
      instr = imem[instrAddr[9:2]];
      #1;
      checkAndAdvance();
      cycles++;
      if (refPc == END_ADDR) tailCycles++;
      @(negedge clk);
    end

    $display("%0d instructions checked", cycles);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
rtl/isaPkg.sv
rtl/corePkg.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/alu.sv
rtl/pcUnit.sv
rtl/dataSram.sv
rtl/mipsCore.sv
rtl/mipsSystem.sv
bench/mipsCore_properties.sv
bench/tbMipsSystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the MIPS subsystem regression with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
  -f files.f \
  --top-module tbMipsSystem \
  -Mdir obj_dir

./obj_dir/VtbMipsSystem > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
